//--- l2wr.f
+incdir+src
src/l2wr_pkg.sv
src/write_buffer.sv
src/write_arbiter.sv
src/l2_write_path.sv
tb/l2wr_sva.sv
tb/tb_l2_write_path.sv

//--- Makefile
# Verilator flow for the L2 write path

TOP     ?= tb_l2_write_path
FLIST   ?= l2wr.f
VFLAGS  ?= --timing --assert
OBJDIR  ?= obj_dir
VERILATOR ?= verilator

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# the run passes only if the testbench printed its pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJDIR) -f $(FLIST) --top-module $(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJDIR)

//--- tb/tb_l2_write_path.sv
`timescale 1ns/10ps
`include "l2wr_config.svh"

module tb_l2_write_path;

    localparam int CLK_PERIOD     = 40;
    localparam int MEM_WORDS      = 256;
    localparam int N_STREAM       = 8;
    localparam int N_MIXED        = 20;
    localparam int NUM_REQS       = 4 + N_STREAM + N_MIXED;
    localparam int CYCLES_PER_REQ = 60;  // a stalled line burst plus one queued behind it
    localparam int TIMEOUT_CYCLES = NUM_REQS * CYCLES_PER_REQ + 200;
    localparam int LOCK_ANY       = 0;
    localparam int LOCK_LOW       = 1;
    localparam int LOCK_HIGH      = 2;

    logic               clk;
    logic               rstn;
    l2wr_pkg::addr_t    req_addr;
    l2wr_pkg::line_t    req_line;
    l2wr_pkg::strb_t    req_strb;
    logic               req_uncached;
    logic               req_valid;
    logic               addr_ok;
    logic               dma_lock;
    l2wr_pkg::addr_t    axi_awaddr;
    l2wr_pkg::len_t     axi_awlen;
    logic               axi_awvalid;
    logic               axi_awready;
    l2wr_pkg::word_t    axi_wdata;
    l2wr_pkg::strb_t    axi_wstrb;
    logic               axi_wvalid;
    logic               axi_wready;
    logic               axi_wlast;
    logic               axi_bvalid;
    logic               axi_bready;

    l2wr_pkg::word_t    mem [MEM_WORDS];
    l2wr_pkg::word_t    ref_mem [MEM_WORDS];
    l2wr_pkg::addr_t    exp_addr_q[$];  // bursts in the order they were requested
    l2wr_pkg::len_t     exp_len_q[$];

    integer             seed;
    logic               stall;
    int                 errors;
    int                 checks;
    int                 issued;
    int                 completed;
    l2wr_pkg::len_t     last_awlen;
    int                 last_beats;
    logic               last_full_strb;

    l2_write_path i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .req_addr     (req_addr),
        .req_line     (req_line),
        .req_strb     (req_strb),
        .req_uncached (req_uncached),
        .req_valid    (req_valid),
        .addr_ok      (addr_ok),
        .dma_lock     (dma_lock),
        .axi_awaddr   (axi_awaddr),
        .axi_awlen    (axi_awlen),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_wdata    (axi_wdata),
        .axi_wstrb    (axi_wstrb),
        .axi_wvalid   (axi_wvalid),
        .axi_wready   (axi_wready),
        .axi_wlast    (axi_wlast),
        .axi_bvalid   (axi_bvalid),
        .axi_bready   (axi_bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check(input string what, input l2wr_pkg::word_t got,
                         input l2wr_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic stall_cycles();
        int n;
        n = stall ? int'($unsigned($random(seed)) % 4) : 0;
        repeat (n) step();
    endtask

    function automatic l2wr_pkg::word_t merge_bytes(input l2wr_pkg::word_t old,
                                                    input l2wr_pkg::word_t data,
                                                    input l2wr_pkg::strb_t strb);
        l2wr_pkg::word_t res;
        res = old;
        for (int b = 0; b < `L2WR_WORD_W/8; b++) begin
            if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic l2wr_pkg::line_t rand_line();
        l2wr_pkg::line_t l;
        for (int i = 0; i < `L2WR_LINE_WORDS; i++) begin
            l[i*`L2WR_WORD_W +: `L2WR_WORD_W] = $random(seed);
        end
        return l;
    endfunction

    // memory slave, stores each beat by strobe at awaddr plus beat
    initial begin : mem_slave
        l2wr_pkg::addr_t base;
        l2wr_pkg::len_t  len;
        logic [7:0]      widx;
        logic            saw_last;
        int              beats;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        wait (rstn === 1'b1);
        forever begin
            stall_cycles();
            axi_awready = 1'b1;
            @(negedge clk);
            while (!axi_awvalid) @(negedge clk);
            base = axi_awaddr;
            len  = axi_awlen;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("memory slave got a burst at %h that no request asked for", base);
            end else begin
                check("burst address", base, exp_addr_q.pop_front());
                check("burst length", 32'(len), 32'(exp_len_q.pop_front()));
            end
            step();
            axi_awready    = 1'b0;
            beats          = 0;
            last_full_strb = 1'b1;
            do begin
                stall_cycles();
                axi_wready = 1'b1;
                @(negedge clk);
                while (!axi_wvalid) @(negedge clk);
                widx = base[9:2] + beats[7:0];
                mem[widx] = merge_bytes(mem[widx], axi_wdata, axi_wstrb);
                if (axi_wstrb != '1) last_full_strb = 1'b0;
                saw_last = axi_wlast;
                beats++;
                step();
                axi_wready = 1'b0;
            end while (!saw_last);
            check("beats in burst", 32'(beats), 32'(int'(len) + 1)); // wlast must match awlen
            last_awlen = len;
            last_beats = beats;
            stall_cycles();
            axi_bvalid = 1'b1;
            @(negedge clk);
            while (!axi_bready) @(negedge clk);
            step();
            axi_bvalid = 1'b0;
            completed++;
        end
    end

    task automatic check_lock(input int mode);
        if (mode == LOCK_LOW) check("dma_lock", 32'(dma_lock), 32'd0);
        else if (mode == LOCK_HIGH) check("dma_lock", 32'(dma_lock), 32'd1);
    endtask

    // one cache request, held until addr_ok
    task automatic write_req(input l2wr_pkg::addr_t addr, input l2wr_pkg::line_t line,
                             input l2wr_pkg::strb_t strb, input logic uncached,
                             input int lock_mode);
        logic [7:0] widx;
        widx = addr[9:2];
        if (uncached) begin
            ref_mem[widx] = merge_bytes(ref_mem[widx], line[`L2WR_WORD_W-1:0], strb);
            exp_len_q.push_back(l2wr_pkg::len_t'(0));
        end else begin
            for (int i = 0; i < `L2WR_LINE_WORDS; i++) begin
                ref_mem[widx + 8'(i)] = line[i*`L2WR_WORD_W +: `L2WR_WORD_W];
            end
            exp_len_q.push_back(l2wr_pkg::len_t'(`L2WR_LINE_WORDS - 1));
        end
        exp_addr_q.push_back(addr);
        issued++;
        req_addr     = addr;
        req_line     = line;
        req_strb     = strb;
        req_uncached = uncached;
        req_valid    = 1'b1;
        @(negedge clk);
        while (!addr_ok) begin
            check_lock(lock_mode);
            @(negedge clk);
        end
        check_lock(lock_mode);
        if (uncached && lock_mode == LOCK_HIGH) begin
            check("axi_bvalid with addr_ok", 32'(axi_bvalid), 32'd1);
        end
        step();
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (completed != issued) step();
    endtask

    task automatic compare_mem();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("memory word %0d", i), mem[i], ref_mem[i]);
        end
    endtask

    task automatic reset_and_line();
        @(negedge clk);
        check("dma_lock after reset", 32'(dma_lock), 32'd0);
        check("axi_awvalid after reset", 32'(axi_awvalid), 32'd0);
        check("axi_wvalid after reset", 32'(axi_wvalid), 32'd0);
        check("addr_ok after reset", 32'(addr_ok), 32'd0);
        step();
        write_req(32'h40, rand_line(), '1, 1'b0, LOCK_LOW);
        drain();
        check("line awlen", 32'(last_awlen), 32'(`L2WR_LINE_WORDS - 1));
        check("line beats", 32'(last_beats), 32'(`L2WR_LINE_WORDS));
        check("line full strobe", 32'(last_full_strb), 32'd1);
        compare_mem();
    endtask

    task automatic direct_write();
        write_req(32'h44, rand_line(), 4'b1010, 1'b1, LOCK_HIGH); // buffer is empty here
        drain();
        check("direct awlen", 32'(last_awlen), 32'd0);
        check("direct beats", 32'(last_beats), 32'd1);
        compare_mem();
    endtask

    task automatic queued_uncached();
        write_req(32'h80, rand_line(), '1, 1'b0, LOCK_LOW);
        write_req(32'h88, rand_line(), 4'b0011, 1'b1, LOCK_LOW); // line still pending
        drain();
        compare_mem();
    endtask

    task automatic line_stream();
        l2wr_pkg::addr_t addr;
        stall = 1'b1;
        for (int n = 0; n < N_STREAM; n++) begin
            addr = 32'h100 + (($unsigned($random(seed)) % 4) * 16); // slots overlap
            write_req(addr, rand_line(), '1, 1'b0, LOCK_LOW);
        end
        drain();
        compare_mem();
    endtask

    task automatic mixed_stream();
        l2wr_pkg::addr_t addr;
        logic            unc;
        stall = 1'b1;
        for (int n = 0; n < N_MIXED; n++) begin
            unc = $unsigned($random(seed)) % 2 == 1;
            if (unc) begin
                addr = 32'h200 + (($unsigned($random(seed)) % 16) * 4);
                write_req(addr, rand_line(), l2wr_pkg::strb_t'($random(seed)), 1'b1, LOCK_ANY);
            end else begin
                addr = 32'h200 + (($unsigned($random(seed)) % 4) * 16);
                write_req(addr, rand_line(), '1, 1'b0, LOCK_ANY);
            end
        end
        drain();
        compare_mem();
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the write path stopped responding",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        seed         = 32'h185cf16f;
        stall        = 1'b0;
        errors       = 0;
        checks       = 0;
        issued       = 0;
        completed    = 0;
        rstn         = 1'b0;
        req_addr     = '0;
        req_line     = '0;
        req_strb     = '0;
        req_uncached = 1'b0;
        req_valid    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = 32'h5a3c0000 ^ (i * 4) ^ (i << 20);
            ref_mem[i] = mem[i];
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        reset_and_line();
        direct_write();
        queued_uncached();
        line_stream();
        mixed_stream();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb/l2wr_sva.sv
`timescale 1ns/10ps

module l2wr_sva (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wb_lock,
    input  logic                    dma_lock,
    input  logic                    axi_awvalid,
    input  logic                    axi_awready,
    input  logic                    axi_wvalid,
    input  logic                    axi_wready,
    input  logic                    axi_wlast,
    input  logic                    axi_bready
);

    logic direct_traffic;

    // with the buffer entry empty, any traffic on the memory channel is a direct write
    assign direct_traffic = (axi_awvalid || axi_wvalid || axi_bready) && !wb_lock;

    awvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        axi_awvalid && !axi_awready |=> axi_awvalid)
        else $error("axi_awvalid dropped before axi_awready");

    wvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        axi_wvalid && !axi_wready |=> axi_wvalid)
        else $error("axi_wvalid dropped before axi_wready");

    // the read side relies on the lock for the whole direct sequence
    lock_in_dma: assert property (@(posedge clk) disable iff (!rstn)
        direct_traffic |-> dma_lock)
        else $error("dma_lock low during a direct write");

    wlast_with_valid: assert property (@(posedge clk) disable iff (!rstn)
        axi_wlast |-> axi_wvalid)
        else $error("axi_wlast without axi_wvalid");

endmodule

bind write_arbiter l2wr_sva i_sva (
    .clk         (clk),
    .rstn        (rstn),
    .wb_lock     (wb_lock),
    .dma_lock    (dma_lock),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_wlast   (axi_wlast),
    .axi_bready  (axi_bready)
);

//--- src/l2_write_path.sv
`timescale 1ns/10ps

module l2_write_path (
    input  logic                clk,
    input  logic                rstn,

    input  l2wr_pkg::addr_t     req_addr,
    input  l2wr_pkg::line_t     req_line,
    input  l2wr_pkg::strb_t     req_strb,
    input  logic                req_uncached,
    input  logic                req_valid,
    output logic                addr_ok,
    output logic                dma_lock,

    output l2wr_pkg::addr_t     axi_awaddr,
    output l2wr_pkg::len_t      axi_awlen,
    output logic                axi_awvalid,
    input  logic                axi_awready,
    output l2wr_pkg::word_t     axi_wdata,
    output l2wr_pkg::strb_t     axi_wstrb,
    output logic                axi_wvalid,
    input  logic                axi_wready,
    output logic                axi_wlast,
    input  logic                axi_bvalid,
    output logic                axi_bready
);

    l2wr_pkg::addr_t    wb_addr;
    l2wr_pkg::line_t    wb_line;
    l2wr_pkg::strb_t    wb_strb;
    logic               wb_single;
    logic               wb_req;
    logic               wb_ack;
    logic               wb_lock;

    l2wr_pkg::addr_t    bm_awaddr;
    l2wr_pkg::len_t     bm_awlen;
    logic               bm_awvalid;
    logic               bm_awready;
    l2wr_pkg::word_t    bm_wdata;
    l2wr_pkg::strb_t    bm_wstrb;
    logic               bm_wvalid;
    logic               bm_wready;
    logic               bm_wlast;
    logic               bm_bvalid;
    logic               bm_bready;

    write_arbiter i_arbiter (
        .clk          (clk),
        .rstn         (rstn),
        .req_addr     (req_addr),
        .req_line     (req_line),
        .req_strb     (req_strb),
        .req_uncached (req_uncached),
        .req_valid    (req_valid),
        .addr_ok      (addr_ok),
        .dma_lock     (dma_lock),
        .wb_addr      (wb_addr),
        .wb_line      (wb_line),
        .wb_strb      (wb_strb),
        .wb_single    (wb_single),
        .wb_req       (wb_req),
        .wb_ack       (wb_ack),
        .wb_lock      (wb_lock),
        .bm_awaddr    (bm_awaddr),
        .bm_awlen     (bm_awlen),
        .bm_awvalid   (bm_awvalid),
        .bm_awready   (bm_awready),
        .bm_wdata     (bm_wdata),
        .bm_wstrb     (bm_wstrb),
        .bm_wvalid    (bm_wvalid),
        .bm_wready    (bm_wready),
        .bm_wlast     (bm_wlast),
        .bm_bvalid    (bm_bvalid),
        .bm_bready    (bm_bready),
        .axi_awaddr   (axi_awaddr),
        .axi_awlen    (axi_awlen),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_wdata    (axi_wdata),
        .axi_wstrb    (axi_wstrb),
        .axi_wvalid   (axi_wvalid),
        .axi_wready   (axi_wready),
        .axi_wlast    (axi_wlast),
        .axi_bvalid   (axi_bvalid),
        .axi_bready   (axi_bready)
    );

    write_buffer i_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line),
        .wb_strb    (wb_strb),
        .wb_single  (wb_single),
        .wb_req     (wb_req),
        .wb_ack     (wb_ack),
        .wb_lock    (wb_lock),
        .bm_awaddr  (bm_awaddr),
        .bm_awlen   (bm_awlen),
        .bm_awvalid (bm_awvalid),
        .bm_awready (bm_awready),
        .bm_wdata   (bm_wdata),
        .bm_wstrb   (bm_wstrb),
        .bm_wvalid  (bm_wvalid),
        .bm_wready  (bm_wready),
        .bm_wlast   (bm_wlast),
        .bm_bvalid  (bm_bvalid),
        .bm_bready  (bm_bready)
    );

endmodule

//--- src/write_arbiter.sv
`timescale 1ns/10ps
`include "l2wr_config.svh"

module write_arbiter (
    input  logic                clk,
    input  logic                rstn,

    // cache request
    input  l2wr_pkg::addr_t     req_addr,
    input  l2wr_pkg::line_t     req_line,
    input  l2wr_pkg::strb_t     req_strb,
    input  logic                req_uncached,
    input  logic                req_valid,
    output logic                addr_ok,
    output logic                dma_lock,

    // write buffer request
    output l2wr_pkg::addr_t     wb_addr,
    output l2wr_pkg::line_t     wb_line,
    output l2wr_pkg::strb_t     wb_strb,
    output logic                wb_single,
    output logic                wb_req,
    input  logic                wb_ack,
    input  logic                wb_lock,

    // write buffer channel
    input  l2wr_pkg::addr_t     bm_awaddr,
    input  l2wr_pkg::len_t      bm_awlen,
    input  logic                bm_awvalid,
    output logic                bm_awready,
    input  l2wr_pkg::word_t     bm_wdata,
    input  l2wr_pkg::strb_t     bm_wstrb,
    input  logic                bm_wvalid,
    output logic                bm_wready,
    input  logic                bm_wlast,
    output logic                bm_bvalid,
    input  logic                bm_bready,

    // memory channel
    output l2wr_pkg::addr_t     axi_awaddr,
    output l2wr_pkg::len_t      axi_awlen,
    output logic                axi_awvalid,
    input  logic                axi_awready,
    output l2wr_pkg::word_t     axi_wdata,
    output l2wr_pkg::strb_t     axi_wstrb,
    output logic                axi_wvalid,
    input  logic                axi_wready,
    output logic                axi_wlast,
    input  logic                axi_bvalid,
    output logic                axi_bready
);

    l2wr_pkg::arb_state_t   state;
    l2wr_pkg::arb_state_t   state_nxt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2wr_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            l2wr_pkg::idle: begin
                if (req_valid) begin
                    // an uncached write goes direct only if nothing is queued ahead of it
                    if (req_uncached && !wb_lock) begin
                        state_nxt = l2wr_pkg::dma_aw;
                    end else begin
                        state_nxt = l2wr_pkg::wrt_w;
                    end
                end
            end
            l2wr_pkg::wrt_w: begin
                if (wb_ack) begin
                    state_nxt = l2wr_pkg::idle;
                end
            end
            l2wr_pkg::dma_aw: begin
                if (axi_awready) begin
                    state_nxt = l2wr_pkg::dma_w;
                end
            end
            l2wr_pkg::dma_w: begin
                if (axi_wready) begin
                    state_nxt = l2wr_pkg::dma_b;
                end
            end
            l2wr_pkg::dma_b: begin
                if (axi_bvalid) begin
                    state_nxt = l2wr_pkg::idle;
                end
            end
            default: begin
                state_nxt = l2wr_pkg::idle;
            end
        endcase
    end

    // request side
    always_comb begin
        addr_ok   = 1'b0;
        dma_lock  = 1'b0;
        wb_req    = 1'b0;
        wb_addr   = req_addr;
        wb_line   = req_line;
        wb_strb   = req_strb;
        wb_single = req_uncached; // queued uncached write keeps its strobe
        case (state)
            l2wr_pkg::idle: begin
                dma_lock = (state_nxt == l2wr_pkg::dma_aw);
            end
            l2wr_pkg::wrt_w: begin
                wb_req  = req_valid;
                addr_ok = wb_ack;
            end
            l2wr_pkg::dma_aw,
            l2wr_pkg::dma_w: begin
                dma_lock = 1'b1;
            end
            l2wr_pkg::dma_b: begin
                dma_lock = 1'b1;
                addr_ok  = axi_bvalid; // done once memory answers
            end
            default: ;
        endcase
    end

    // memory channel owner
    always_comb begin
        bm_awready  = 1'b0;
        bm_wready   = 1'b0;
        bm_bvalid   = 1'b0;
        axi_awaddr  = req_addr;
        axi_awlen   = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = req_line[`L2WR_WORD_W-1:0]; // direct write uses word 0
        axi_wstrb   = req_strb;
        axi_wvalid  = 1'b0;
        axi_wlast   = 1'b0;
        axi_bready  = 1'b0;
        case (state)
            l2wr_pkg::idle,
            l2wr_pkg::wrt_w: begin
                axi_awaddr  = bm_awaddr;
                axi_awlen   = bm_awlen;
                axi_awvalid = bm_awvalid;
                axi_wdata   = bm_wdata;
                axi_wstrb   = bm_wstrb;
                axi_wvalid  = bm_wvalid;
                axi_wlast   = bm_wlast;
                axi_bready  = bm_bready;
                bm_awready  = axi_awready;
                bm_wready   = axi_wready;
                bm_bvalid   = axi_bvalid;
            end
            l2wr_pkg::dma_aw: begin
                axi_awvalid = 1'b1;
            end
            l2wr_pkg::dma_w: begin
                axi_wvalid = 1'b1;
                axi_wlast  = 1'b1; // single beat
            end
            l2wr_pkg::dma_b: begin
                axi_bready = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- src/write_buffer.sv
`timescale 1ns/10ps
`include "l2wr_config.svh"

module write_buffer (
    input  logic                clk,
    input  logic                rstn,

    input  l2wr_pkg::addr_t     wb_addr,
    input  l2wr_pkg::line_t     wb_line,
    input  l2wr_pkg::strb_t     wb_strb,
    input  logic                wb_single,
    input  logic                wb_req,
    output logic                wb_ack,
    output logic                wb_lock,

    output l2wr_pkg::addr_t     bm_awaddr,
    output l2wr_pkg::len_t      bm_awlen,
    output logic                bm_awvalid,
    input  logic                bm_awready,
    output l2wr_pkg::word_t     bm_wdata,
    output l2wr_pkg::strb_t     bm_wstrb,
    output logic                bm_wvalid,
    input  logic                bm_wready,
    output logic                bm_wlast,
    input  logic                bm_bvalid,
    output logic                bm_bready
);

    l2wr_pkg::wb_state_t            state;
    l2wr_pkg::wb_state_t            state_nxt;

    l2wr_pkg::addr_t                e_addr;
    l2wr_pkg::line_t                e_line;
    l2wr_pkg::strb_t                e_strb;
    logic                           e_single;

    logic [`L2WR_OFFSET_WIDTH-1:0]  beat_cnt;
    logic                           last_beat;
    logic                           capture;

    // entry takes a request only when nothing is pending
    assign capture   = wb_req && (state == l2wr_pkg::empty);
    assign wb_ack    = capture;
    assign wb_lock   = (state != l2wr_pkg::empty);

    assign last_beat = e_single || (&beat_cnt); // single beat or final word of the line

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2wr_pkg::empty;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            l2wr_pkg::empty: begin
                if (capture) begin
                    state_nxt = l2wr_pkg::aw;
                end
            end
            l2wr_pkg::aw: begin
                if (bm_awready) begin
                    state_nxt = l2wr_pkg::w;
                end
            end
            l2wr_pkg::w: begin
                if (bm_wready && last_beat) begin
                    state_nxt = l2wr_pkg::b;
                end
            end
            l2wr_pkg::b: begin
                if (bm_bvalid) begin
                    state_nxt = l2wr_pkg::empty; // entry freed on the response
                end
            end
            default: begin
                state_nxt = l2wr_pkg::empty;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            e_addr   <= wb_addr;
            e_line   <= wb_line;
            e_strb   <= wb_strb;
            e_single <= wb_single;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (state == l2wr_pkg::aw) begin
            beat_cnt <= '0;
        end else if (state == l2wr_pkg::w && bm_wready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // payload follows the entry, the valids gate it
    always_comb begin
        bm_awaddr  = e_addr;
        bm_awlen   = e_single ? '0 : l2wr_pkg::len_t'(`L2WR_LINE_WORDS - 1);
        bm_wdata   = e_line[beat_cnt*`L2WR_WORD_W +: `L2WR_WORD_W];
        bm_wstrb   = e_single ? e_strb : '1;
        bm_awvalid = (state == l2wr_pkg::aw);
        bm_wvalid  = (state == l2wr_pkg::w);
        bm_wlast   = (state == l2wr_pkg::w) && last_beat;
        bm_bready  = (state == l2wr_pkg::b);
    end

endmodule

//--- src/l2wr_pkg.sv
`include "l2wr_config.svh"

package l2wr_pkg;

    typedef logic [`L2WR_ADDR_W-1:0]                     addr_t; // byte address
    typedef logic [`L2WR_WORD_W-1:0]                     word_t; // one data beat
    typedef logic [`L2WR_LINE_WORDS*`L2WR_WORD_W-1:0]    line_t; // word 0 in the low bits
    typedef logic [`L2WR_WORD_W/8-1:0]                   strb_t;
    typedef logic [7:0]                                  len_t;  // beats minus one

    typedef enum logic [2:0] {
        idle,
        wrt_w,   // request handed to the write buffer
        dma_aw,
        dma_w,
        dma_b
    } arb_state_t;

    typedef enum logic [1:0] {
        empty,
        aw,
        w,
        b
    } wb_state_t;

endpackage

//--- src/l2wr_config.svh
`ifndef L2WR_CONFIG_SVH
`define L2WR_CONFIG_SVH

// log2 of the words held in one cache line
`define L2WR_OFFSET_WIDTH 2

`define L2WR_LINE_WORDS (1 << `L2WR_OFFSET_WIDTH)

`define L2WR_ADDR_W 32

`define L2WR_WORD_W 32

`endif
